// ==== ahb_mtx_input_stage.f ====
rtl/ahb_pkg.sv
rtl/mtx_pkg.sv
rtl/ahb_mtx_port_ctrl.sv
rtl/ahb_mtx_hold_stage.sv
rtl/ahb_mtx_burst_fixup.sv
rtl/ahb_mtx_input_stage.sv
tests/ahb_mtx_input_stage_properties.sv
tests/tb_clock_gen.sv
tests/tb_ahb_mtx_input_stage.sv

// ==== rtl/ahb_mtx_burst_fixup.sv ====
`timescale 1ns/1ns

// Early burst termination and wrap-boundary trans rewrite
module ahb_mtx_burst_fixup (
  input  logic                HCLK,
  input  logic                HRESETn,
  input  mtx_pkg::ahb_ctrl_t  s_ctrl,      // Control from master
  input  logic                HREADYS,     // Bus ready
  input  logic                accept,      // Valid beat accepted
  input  logic                active_ip,   // Port owns output stage
  input  logic                holding,     // Replaying stored beat
  input  ahb_pkg::htrans_e    held_trans,  // Raw trans of stored beat
  input  mtx_pkg::ahb_ctrl_t  mux_ctrl,    // Direct or held control
  output mtx_pkg::ahb_ctrl_t  m_ctrl       // Control toward output stage
);

  import ahb_pkg::*;
  import mtx_pkg::*;

  logic                  override;    // Burst continued as INCR
  logic                  bound;       // Last beat hit wrap boundary
  logic [WRAP_IDX_W-1:0] offset;      // Beat index within address
  logic [WRAP_IDX_W-1:0] check_idx;   // Offset padded with ones
  htrans_e               trans_used;  // Trans that picks the burst

  // --------------------------------------------------
  // Early burst termination
  // --------------------------------------------------
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      override <= 1'b0;
    else if (HREADYS)
    begin
      if ((s_ctrl.trans == NONSEQ) || (s_ctrl.trans == IDLE))
        override <= 1'b0;        // New burst or bus idle
      else if ((s_ctrl.trans == SEQ) && accept && !active_ip)
        override <= 1'b1;        // Burst broken by arbitration
    end
  end

  // --------------------------------------------------
  // Wrap boundary
  // --------------------------------------------------
  always_comb
  begin
    case (s_ctrl.size)
      SIZE_BYTE:  offset = s_ctrl.addr[WRAP_IDX_W-1:0];
      SIZE_HWORD: offset = s_ctrl.addr[WRAP_IDX_W:1];
      SIZE_WORD:  offset = s_ctrl.addr[WRAP_IDX_W+1:2];
      SIZE_DWORD: offset = s_ctrl.addr[WRAP_IDX_W+2:3];
      default:    offset = s_ctrl.addr[WRAP_IDX_W-1:0];  // 128 bits and up
    endcase
  end

  // Bits above the wrap length count as ones
  always_comb
  begin
    case (s_ctrl.burst)
      WRAP4:   check_idx = {{(WRAP_IDX_W-2){1'b1}}, offset[1:0]};
      WRAP8:   check_idx = {{(WRAP_IDX_W-3){1'b1}}, offset[2:0]};
      WRAP16:  check_idx = offset;
      default: check_idx = '0;   // Never a boundary
    endcase
  end

  // Sampled on every NONSEQ or SEQ that moves
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      bound <= 1'b0;
    else if (s_ctrl.trans[1] && HREADYS)
      bound <= &check_idx;
  end

  // --------------------------------------------------
  // Outgoing control
  // --------------------------------------------------
  assign trans_used = holding ? held_trans : s_ctrl.trans;

  always_comb
  begin
    m_ctrl = mux_ctrl;
    if (override && bound)
      m_ctrl.trans = htrans_e'({mux_ctrl.trans[1], 1'b0});  // SEQ->NONSEQ, BUSY->IDLE
    if (override && (trans_used != NONSEQ))
      m_ctrl.burst = INCR;       // Rest of burst as undefined length
  end

endmodule

// ==== rtl/ahb_mtx_hold_stage.sv ====
`timescale 1ns/1ns

// Holding register for a beat the output stage could not take
module ahb_mtx_hold_stage (
  input  logic                HCLK,
  input  logic                HRESETn,
  input  mtx_pkg::ahb_ctrl_t  s_ctrl,        // Control from master
  input  logic                accept,        // Valid beat accepted
  input  logic                active_ip,     // Port owns output stage
  input  mtx_pkg::slv_resp_t  m_resp,        // Output-stage response
  output logic                holding,       // Pending beat in register
  output ahb_pkg::htrans_e    held_trans,    // Raw trans of stored beat
  output logic                held_tran_ip,  // Arbitration request
  output mtx_pkg::ahb_ctrl_t  mux_ctrl       // Direct or held control
);

  import ahb_pkg::*;
  import mtx_pkg::*;

  ahb_ctrl_t hold_reg;  // Stored address phase

  // --------------------------------------------------
  // Holding register
  // --------------------------------------------------
  // Captures every accepted beat. Only read back once
  // the pending flag says the output stage missed it.
  always_ff @(posedge HCLK)
  begin
    if (accept)
      hold_reg <= s_ctrl;
  end

  // Original trans, needed by burst fixup when replaying
  assign held_trans = hold_reg.trans;

  // --------------------------------------------------
  // Pending flag
  // --------------------------------------------------
  // Set when a beat arrives and the output stage is
  // serving another port. Cleared when the replayed beat
  // is driven out and the slave signals ready.
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      holding <= 1'b0;
    end
    else if (accept && !active_ip)
    begin
      holding <= 1'b1;           // Output stage busy elsewhere
    end
    else if (active_ip && m_resp.ready)
    begin
      holding <= 1'b0;           // Replayed beat taken
    end
  end

  // Request stays up from accept until replay is done
  assign held_tran_ip = accept || holding;

  // --------------------------------------------------
  // Direct / held mux
  // --------------------------------------------------
  always_comb
  begin
    if (!holding)
    begin
      mux_ctrl = s_ctrl;         // Pass through
    end
    else
    begin
      mux_ctrl       = hold_reg;
      mux_ctrl.sel   = 1'b1;     // Held beat is always selected
      mux_ctrl.trans = NONSEQ;   // Replay restarts the sequence
    end
  end

endmodule

// ==== rtl/ahb_mtx_input_stage.sv ====
`timescale 1ns/1ns

// Input stage of the bus matrix, one per master port
module ahb_mtx_input_stage (
  input  logic                HCLK,
  input  logic                HRESETn,

  // Master side
  input  mtx_pkg::ahb_ctrl_t  s_ctrl,        // Address-phase control from master
  input  logic                HREADYS,       // Bus ready seen by the master
  output logic                HREADYOUTS,    // Ready back to master
  output ahb_pkg::hresp_e     HRESPS,        // Response back to master

  // Output-stage side
  input  logic                active_ip,     // This port owns the output stage
  input  mtx_pkg::slv_resp_t  m_resp,        // Response from output stage
  output mtx_pkg::ahb_ctrl_t  m_ctrl,        // Control toward output stage
  output logic                held_tran_ip   // Request to arbitration
);

  import ahb_pkg::*;
  import mtx_pkg::*;

  // --------------------------------------------------
  // Stage-to-stage wires
  // --------------------------------------------------
  logic       accept;     // Valid beat taken this edge
  logic       holding;    // Beat parked in holding register
  htrans_e    held_trans; // Original trans of parked beat
  ahb_ctrl_t  mux_ctrl;   // Direct or held control

  // Qualify address phase, own the response
  ahb_mtx_port_ctrl u_port_ctrl (
    .HCLK       (HCLK),
    .HRESETn    (HRESETn),
    .s_ctrl     (s_ctrl),
    .HREADYS    (HREADYS),
    .holding    (holding),
    .m_resp     (m_resp),
    .accept     (accept),
    .HREADYOUTS (HREADYOUTS),
    .HRESPS     (HRESPS)
  );

  // Park and replay
  ahb_mtx_hold_stage u_hold_stage (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .s_ctrl       (s_ctrl),
    .accept       (accept),
    .active_ip    (active_ip),
    .m_resp       (m_resp),
    .holding      (holding),
    .held_trans   (held_trans),
    .held_tran_ip (held_tran_ip),
    .mux_ctrl     (mux_ctrl)
  );

  // Fix up trans and burst on the way out
  ahb_mtx_burst_fixup u_burst_fixup (
    .HCLK       (HCLK),
    .HRESETn    (HRESETn),
    .s_ctrl     (s_ctrl),
    .HREADYS    (HREADYS),
    .accept     (accept),
    .active_ip  (active_ip),
    .holding    (holding),
    .held_trans (held_trans),
    .mux_ctrl   (mux_ctrl),
    .m_ctrl     (m_ctrl)
  );

endmodule

// ==== rtl/ahb_mtx_port_ctrl.sv ====
`timescale 1ns/1ns

// Address-phase qualification and master-side response
module ahb_mtx_port_ctrl (
  input  logic                HCLK,
  input  logic                HRESETn,
  input  mtx_pkg::ahb_ctrl_t  s_ctrl,      // Control from master
  input  logic                HREADYS,     // Bus ready
  input  logic                holding,     // Beat parked in hold stage
  input  mtx_pkg::slv_resp_t  m_resp,      // Output-stage response
  output logic                accept,      // Valid beat accepted
  output logic                HREADYOUTS,  // Ready to master
  output ahb_pkg::hresp_e     HRESPS       // Response to master
);

  import ahb_pkg::*;

  logic addr_valid;  // Selected and NONSEQ or SEQ
  logic data_valid;  // Data phase owed to master

  // --------------------------------------------------
  // Address phase
  // --------------------------------------------------
  // IDLE and BUSY carry no data phase
  assign addr_valid = s_ctrl.sel &&
                      ((s_ctrl.trans == NONSEQ) || (s_ctrl.trans == SEQ));

  assign accept = addr_valid && HREADYS;  // Beat taken on this edge

  // Data phase follows an accepted address phase
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      data_valid <= 1'b0;
    else if (HREADYS)
      data_valid <= addr_valid;  // Only advances when bus moves
  end

  // --------------------------------------------------
  // Response mux
  // --------------------------------------------------
  always_comb
  begin
    if (!data_valid)
    begin
      HREADYOUTS = 1'b1;         // Nothing owed, zero wait OKAY
      HRESPS     = OKAY;
    end
    else if (holding)
    begin
      HREADYOUTS = 1'b0;         // Stall until replay completes
      HRESPS     = OKAY;
    end
    else
    begin
      HREADYOUTS = m_resp.ready; // Straight from slave
      HRESPS     = m_resp.resp;
    end
  end

endmodule

// ==== rtl/ahb_pkg.sv ====
// AHB protocol encodings shared by the matrix input stage
package ahb_pkg;

  // --------------------------------------------------
  // Bus widths
  // --------------------------------------------------
  localparam int ADDR_W   = 32;  // HADDR width
  localparam int PROT_W   = 4;   // HPROT width
  localparam int MASTER_W = 4;   // HMASTER width

  // --------------------------------------------------
  // Transfer type
  // --------------------------------------------------
  typedef enum logic [1:0] {
    IDLE   = 2'b00,  // No transfer
    BUSY   = 2'b01,  // Master inserting a wait in a burst
    NONSEQ = 2'b10,  // First beat or single
    SEQ    = 2'b11   // Remaining beats of a burst
  } htrans_e;

  // --------------------------------------------------
  // Burst type
  // --------------------------------------------------
  typedef enum logic [2:0] {
    SINGLE = 3'b000,  // Single beat
    INCR   = 3'b001,  // Undefined length incrementing
    WRAP4  = 3'b010,
    INCR4  = 3'b011,
    WRAP8  = 3'b100,
    INCR8  = 3'b101,
    WRAP16 = 3'b110,
    INCR16 = 3'b111
  } hburst_e;

  // Transfer size, byte up to 1024 bits
  typedef enum logic [2:0] {
    SIZE_BYTE  = 3'b000,
    SIZE_HWORD = 3'b001,
    SIZE_WORD  = 3'b010,
    SIZE_DWORD = 3'b011,
    SIZE_128   = 3'b100,
    SIZE_256   = 3'b101,
    SIZE_512   = 3'b110,
    SIZE_1024  = 3'b111
  } hsize_e;

  // Response, two bits to match the bus encoding
  typedef enum logic [1:0] {
    OKAY  = 2'b00,
    ERROR = 2'b01
  } hresp_e;

endpackage

// ==== rtl/mtx_pkg.sv ====
// Matrix-internal bundles between input stage and output stage
package mtx_pkg;

  // Beat offset width for wrap boundary checks
  localparam int WRAP_IDX_W = 4;

  // --------------------------------------------------
  // Address-phase control
  // --------------------------------------------------
  typedef struct packed {
    logic                            sel;       // Port select
    logic [ahb_pkg::ADDR_W-1:0]      addr;      // Byte address
    ahb_pkg::htrans_e                trans;     // Transfer type
    logic                            write;     // 1 for write
    ahb_pkg::hsize_e                 size;      // Beat size
    ahb_pkg::hburst_e                burst;     // Burst type
    logic [ahb_pkg::PROT_W-1:0]      prot;      // Protection bits
    logic [ahb_pkg::MASTER_W-1:0]    master;    // Master number
    logic                            mastlock;  // Locked sequence
  } ahb_ctrl_t;

  // --------------------------------------------------
  // Response from the output stage
  // --------------------------------------------------
  typedef struct packed {
    logic             ready;  // HREADYOUT of the selected slave
    ahb_pkg::hresp_e  resp;   // HRESP of the selected slave
  } slv_resp_t;

endpackage

// ==== tests/ahb_mtx_input_stage_properties.sv ====
`timescale 1ns/1ns

// Port-level protocol checks, bound into the input stage
module ahb_mtx_input_stage_properties (
  input logic               HCLK,
  input logic               HRESETn,
  input logic               HREADYOUTS,
  input logic               held_tran_ip,
  input logic               active_ip,
  input mtx_pkg::slv_resp_t m_resp,
  input mtx_pkg::ahb_ctrl_t m_ctrl
);

  import ahb_pkg::*;

  int fail_cnt = 0;  // Failed assertion count, polled by the testbench

  // Nothing owed right after reset
  a_ready_after_reset : assert property (@(posedge HCLK) !HRESETn |=> HREADYOUTS)
  else
  begin
    fail_cnt++;
    $error("HREADYOUTS low in the first cycle after reset");
  end

  // Request stays up while the output stage is away
  a_held_stays : assert property (@(posedge HCLK) disable iff (!HRESETn)
    held_tran_ip && !active_ip |=> held_tran_ip)
  else
  begin
    fail_cnt++;
    $error("held_tran_ip dropped before the held beat completed");
  end

  // Stall with a ready slave only comes from holding, and replay is NONSEQ
  a_no_seq_in_hold : assert property (@(posedge HCLK) disable iff (!HRESETn)
    !HREADYOUTS && m_resp.ready |-> m_ctrl.trans != SEQ)
  else
  begin
    fail_cnt++;
    $error("m_ctrl.trans is SEQ while the master is stalled by holding");
  end

endmodule

// ==== tests/tb_ahb_mtx_input_stage.sv ====
`timescale 1ns/1ns

// Testbench for the bus matrix input stage
module tb_ahb_mtx_input_stage;

  import ahb_pkg::*;
  import mtx_pkg::*;

  localparam int        STIM_CYCLES = 400;              // Rough stimulus length
  localparam int        MAX_CYCLES  = 5 * STIM_CYCLES;  // Hang guard
  localparam slv_resp_t RESP_OK     = '{ready: 1'b1, resp: OKAY};
  localparam hburst_e   WRAPS [3]   = '{WRAP4, WRAP8, WRAP16};

  // Expected outputs for one cycle
  typedef struct packed {
    ahb_ctrl_t ctrl;
    slv_resp_t resp;
    logic      held;
  } exp_t;

  logic      HCLK;
  logic      HRESETn;
  ahb_ctrl_t s_ctrl;
  ahb_ctrl_t m_ctrl;
  logic      HREADYS;
  logic      active_ip;
  logic      HREADYOUTS;
  logic      held_tran_ip;
  slv_resp_t m_resp;
  hresp_e    HRESPS;
  integer    seed        = 32'h01e0a0e1;
  int        cycles      = 0;
  int        checks_done = 0;

  // Reference model state
  logic      r_hold  = 1'b0;  // Pending beat
  logic      r_dv    = 1'b0;  // Data phase owed
  logic      r_ovr   = 1'b0;  // Burst override
  logic      r_bound = 1'b0;  // Wrap boundary seen
  ahb_ctrl_t r_store;         // Last accepted beat

  tb_clock_gen u_clk (
    .HCLK    (HCLK),
    .HRESETn (HRESETn)
  );

  ahb_mtx_input_stage u_dut (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .s_ctrl       (s_ctrl),
    .HREADYS      (HREADYS),
    .HREADYOUTS   (HREADYOUTS),
    .HRESPS       (HRESPS),
    .active_ip    (active_ip),
    .m_resp       (m_resp),
    .m_ctrl       (m_ctrl),
    .held_tran_ip (held_tran_ip)
  );

  bind ahb_mtx_input_stage ahb_mtx_input_stage_properties u_props (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .HREADYOUTS   (HREADYOUTS),
    .held_tran_ip (held_tran_ip),
    .active_ip    (active_ip),
    .m_resp       (m_resp),
    .m_ctrl       (m_ctrl)
  );

  // --------------------------------------------------
  // Random helpers
  // --------------------------------------------------
  function automatic logic [31:0] rnd();
    return $random(seed);
  endfunction

  function automatic logic chance(input int pct);
    return (rnd() % 100) < pct;
  endfunction

  function automatic ahb_ctrl_t rand_ctrl();
    logic [63:0] bits;
    bits = {rnd(), rnd()};
    return bits[$bits(ahb_ctrl_t)-1:0];  // Every field encoding is legal
  endfunction

  function automatic slv_resp_t rand_resp(input int pct_ready, input int pct_err);
    slv_resp_t r;
    r.ready = chance(pct_ready);
    r.resp  = chance(pct_err) ? ERROR : OKAY;
    return r;
  endfunction

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------
  function automatic logic is_valid(input ahb_ctrl_t c);
    return c.sel && (c.trans == NONSEQ || c.trans == SEQ);
  endfunction

  // Beat sits at the last slot before the wrap point
  function automatic logic wrap_last(input ahb_ctrl_t c);
    logic [31:0] idx;
    idx = (c.size < SIZE_128) ? (c.addr >> c.size) : c.addr;  // Byte offset for wide sizes
    case (c.burst)
      WRAP4:   return idx[1:0] == 2'b11;
      WRAP8:   return idx[2:0] == 3'b111;
      WRAP16:  return idx[3:0] == 4'hf;
      default: return 1'b0;
    endcase
  endfunction

  function automatic exp_t ref_outputs(input ahb_ctrl_t s, input logic rdy,
                                       input slv_resp_t r);
    exp_t    e;
    htrans_e t_use;
    e.held = (is_valid(s) && rdy) || r_hold;
    e.resp = r;
    if (!r_dv)
      e.resp = RESP_OK;            // Zero-wait OKAY
    else if (r_hold)
    begin
      e.resp.ready = 1'b0;         // Stall during replay
      e.resp.resp  = OKAY;
    end
    e.ctrl = s;
    if (r_hold)
    begin
      e.ctrl       = r_store;
      e.ctrl.sel   = 1'b1;
      e.ctrl.trans = NONSEQ;
    end
    t_use = r_hold ? r_store.trans : s.trans;
    if (r_ovr && r_bound)
    begin
      if (e.ctrl.trans == SEQ)
        e.ctrl.trans = NONSEQ;     // Wrap point restarts the burst
      else if (e.ctrl.trans == BUSY)
        e.ctrl.trans = IDLE;
    end
    if (r_ovr && t_use != NONSEQ)
      e.ctrl.burst = INCR;
    return e;
  endfunction

  // State after the coming rising edge
  task automatic update_model(input ahb_ctrl_t s, input logic rdy, input logic act,
                              input slv_resp_t r, input logic rst_n);
    logic acc;
    acc = is_valid(s) && rdy;
    if (acc)
      r_store = s;
    if (!rst_n)
    begin
      r_hold  = 1'b0;
      r_dv    = 1'b0;
      r_ovr   = 1'b0;
      r_bound = 1'b0;
    end
    else
    begin
      if (acc && !act)
        r_hold = 1'b1;
      else if (act && r.ready)
        r_hold = 1'b0;
      if (rdy)
      begin
        r_dv = is_valid(s);
        if (s.trans == NONSEQ || s.trans == IDLE)
          r_ovr = 1'b0;
        else if (s.trans == SEQ && acc && !act)
          r_ovr = 1'b1;
        if (s.trans == NONSEQ || s.trans == SEQ)
          r_bound = wrap_last(s);
      end
    end
  endtask

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------
  task automatic fail_stop(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_ctrl(input string name, input ahb_ctrl_t got, input ahb_ctrl_t exp);
    if (got !== exp)
      fail_stop($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic check_resp(input string name, input slv_resp_t got, input slv_resp_t exp);
    if (got !== exp)
      fail_stop($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic check_held(input string name, input logic got, input logic exp);
    if (got !== exp)
      fail_stop($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  // Inputs settle after posedge, so compare at negedge
  always @(negedge HCLK)
  begin
    exp_t      e;
    slv_resp_t got;
    if (HRESETn)
    begin
      e         = ref_outputs(s_ctrl, HREADYS, m_resp);
      got.ready = HREADYOUTS;
      got.resp  = HRESPS;
      check_ctrl("m_ctrl", m_ctrl, e.ctrl);
      check_resp("HREADYOUTS/HRESPS", got, e.resp);
      check_held("held_tran_ip", held_tran_ip, e.held);
      if (u_dut.u_props.fail_cnt != 0)
        fail_stop("a bound protocol assertion failed");
      checks_done++;
    end
    update_model(s_ctrl, HREADYS, active_ip, m_resp, HRESETn);
  end

  always @(posedge HCLK)
  begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES)
      fail_stop("timeout, stimulus did not finish within the cycle limit");
  end

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  task automatic drive(input ahb_ctrl_t c, input logic rdy, input logic act,
                       input slv_resp_t r);
    @(posedge HCLK);
    s_ctrl    <= c;
    HREADYS   <= rdy;
    active_ip <= act;
    m_resp    <= r;
  endtask

  task automatic hold_replay();
    ahb_ctrl_t   c;
    ahb_ctrl_t   nxt;
    logic [31:0] v;
    c       = rand_ctrl();
    c.sel   = 1'b1;
    c.trans = NONSEQ;
    nxt     = rand_ctrl();
    v       = rnd();
    drive(c, 1'b1, 1'b0, RESP_OK);      // Output stage busy elsewhere
    repeat (1 + v % 4)
      drive(nxt, 1'b0, 1'b0, rand_resp(50, 0));
    drive(nxt, 1'b0, 1'b1, RESP_OK);    // Replay taken
    drive(nxt, 1'b1, 1'b1, RESP_OK);
  endtask

  // Second beat lands while the output stage is away
  task automatic run_burst(input hburst_e b);
    ahb_ctrl_t   c;
    logic [31:0] start;
    logic [31:0] step;
    logic [31:0] bytes;
    int          len;
    int          k;
    c       = rand_ctrl();
    c.sel   = 1'b1;
    c.burst = b;
    start   = c.addr;
    step    = 32'd1 << c.size;
    len     = (b == WRAP4 || b == INCR4) ? 4 : (b == WRAP8 || b == INCR8) ? 8 : 16;
    bytes   = step * len;
    k       = 0;
    while (k < len)
    begin
      if (b == WRAP4 || b == WRAP8 || b == WRAP16)
        c.addr = (start & ~(bytes - 1)) | ((start + k * step) & (bytes - 1));
      else
        c.addr = start + k * step;
      if (k == 0)
        c.trans = NONSEQ;
      else if (k > 1 && chance(20))
        c.trans = BUSY;            // Address already shows next beat
      else
        c.trans = SEQ;
      drive(c, 1'b1, k != 1, RESP_OK);
      if (k == 1)
        drive(c, 1'b0, 1'b1, RESP_OK);  // Held beat replays, master stalled
      if (c.trans != BUSY)
        k++;
    end
    c.trans = IDLE;
    drive(c, 1'b1, 1'b1, RESP_OK);
  endtask

  initial
  begin
    ahb_ctrl_t c;
    s_ctrl    = '0;
    HREADYS   = 1'b1;
    active_ip = 1'b1;
    m_resp    = RESP_OK;
    wait (HRESETn);

    // Pass-through, output stage always ours
    repeat (80)
    begin
      c     = rand_ctrl();
      c.sel = chance(90);
      drive(c, chance(85), 1'b1, rand_resp(80, 0));
    end
    repeat (6)
      hold_replay();

    // Idle, BUSY or unselected beats
    repeat (40)
    begin
      c = rand_ctrl();
      if (chance(50))
        c.sel = 1'b0;
      else
        c.trans = chance(50) ? IDLE : BUSY;
      drive(c, 1'b1, chance(50), rand_resp(50, 50));
    end

    repeat (4)
      run_burst(INCR8);
    repeat (2)
      run_burst(INCR16);
    repeat (12)
      run_burst(WRAPS[rnd() % 3]);

    // Slave errors on owed data phases
    repeat (40)
    begin
      c       = rand_ctrl();
      c.sel   = 1'b1;
      c.trans = NONSEQ;
      drive(c, 1'b1, 1'b1, rand_resp(90, 40));
    end
    repeat (60)
      drive(rand_ctrl(), chance(80), chance(70), rand_resp(70, 20));
    repeat (2)
      @(posedge HCLK);

    if (checks_done >= STIM_CYCLES)
    begin
      $display("Result: PASSED");
      $finish;
    end
    else
    begin
      $display("too few compare cycles ran: %0d", checks_done);
      $display("Result: FAILED");
      $fatal(1, "run stopped");
    end
  end

endmodule

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/1ns

// Free-running bus clock and power-on reset
module tb_clock_gen (
  output logic HCLK,
  output logic HRESETn
);

  localparam int HALF_PERIOD = 4;  // 8 ns period

  initial
  begin
    HCLK    = 1'b0;
    HRESETn = 1'b0;
    repeat (2)
      @(posedge HCLK);
    HRESETn <= 1'b1;               // Released on a rising edge
  end

  always #HALF_PERIOD HCLK = ~HCLK;

endmodule
